// File: files.f
+incdir+hdl
+incdir+testbench
hdl/tspp_pkg.sv
hdl/control_unit.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/branch_res.sv
hdl/fetch_stage.sv
hdl/execute_stage.sv
hdl/tspp_top.sv
testbench/tb_tspp.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the tb_tspp simulation with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal -f files.f \
  --top-module tb_tspp --Mdir "$OBJ" -o Vtb_tspp
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ/Vtb_tspp" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "Finished with no errors" "$LOG"; then
  exit 0
fi
exit 1

// File: testbench/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Bus activity expected in one execute cycle
localparam logic [1:0] EV_IDLE  = 2'd0;
localparam logic [1:0] EV_LOAD  = 2'd1;
localparam logic [1:0] EV_STORE = 2'd2;
localparam logic [1:0] EV_FAULT = 2'd3;

// One entry per DUT cycle, bubbles included
typedef struct packed {
  word_t      fetch_addr;
  logic [1:0] kind;
  word_t      addr;
  logic [3:0] byte_en;
  word_t      wdata;
} cycle_exp_t;

int         seed;
word_t      m_regs [32];
logic [7:0] m_mem [256];
cycle_exp_t exp_q [$];
int         exp_writes;
// Fetch address that stays on the bus once halted
word_t      exp_halt_fetch;

function automatic int rand_below(input int n);
  int r;
  r = $random(seed);
  return (r & 32'h7fff_ffff) % n;
endfunction

// Bijective over the 256-byte window
function automatic logic [7:0] fill_byte(input int a);
  return 8'(a * 167 + 29);
endfunction

// RV32I instruction formats
function automatic word_t r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                 input logic [4:0] rs1, input logic [2:0] f3,
                                 input logic [4:0] rd);
  return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic word_t i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                 input logic [2:0] f3, input logic [4:0] rd,
                                 input logic [6:0] op);
  return {imm, rs1, f3, rd, op};
endfunction

function automatic word_t s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                 input logic [4:0] rs1, input logic [2:0] f3);
  return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
endfunction

function automatic word_t b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                 input logic [4:0] rs1, input logic [2:0] f3);
  return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
endfunction

function automatic word_t u_type(input logic [19:0] imm, input logic [4:0] rd,
                                 input logic [6:0] op);
  return {imm, rd, op};
endfunction

function automatic word_t j_type(input logic [20:0] imm, input logic [4:0] rd);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
endfunction

// Random program where all control flow goes forward and always reaches ECALL
task automatic gen_program();
  int          i;
  int          kind;
  int          k;
  int          off;
  logic [4:0]  rd;
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic [2:0]  f3;
  logic [11:0] imm;
  logic        mis;
  for (i = 0; i < PROG_LEN - 1; i++) begin
    // First slot is plain ALU so the cycle after reset is quiet
    kind = (i == 0) ? 0 : rand_below(10);
    rd   = 5'(1 + rand_below(15));
    rs1  = 5'(rand_below(16));
    rs2  = 5'(rand_below(16));
    f3   = 3'(rand_below(8));
    imm  = 12'($random(seed));
    k    = 1 + rand_below(4);
    if (i + k > PROG_LEN - 1) begin
      k = PROG_LEN - 1 - i;
    end
    // Roughly one memory access in eight is misaligned
    mis = (rand_below(8) == 0);
    case (kind)
      0, 1, 2: begin
        // Shift immediates carry funct7 in the upper bits
        if (f3 == 3'd1) begin
          imm = {7'd0, imm[4:0]};
        end
        if (f3 == 3'd5) begin
          imm = {1'b0, imm[10], 5'd0, imm[4:0]};
        end
        imem[i] = i_type(imm, rs1, f3, rd, 7'b0010011);
      end
      3, 4: begin
        imem[i] = r_type((f3 == 3'd0 || f3 == 3'd5) ? {1'b0, imm[0], 5'd0} : 7'd0,
                         rs2, rs1, f3, rd);
      end
      5: begin
        imem[i] = u_type(20'($random(seed)), rd, imm[0] ? 7'b0110111 : 7'b0010111);
      end
      6: begin
        // SB, SH, SW with x0 base into the data window
        f3  = 3'(rand_below(3));
        off = rand_below(256) & ~((1 << f3) - 1);
        if (mis && f3 != 3'd0) begin
          off = off + 1;
        end
        imem[i] = s_type(12'(off), rs2, 5'd0, f3);
      end
      7: begin
        // LB LH LW LBU LHU
        f3 = 3'(rand_below(5));
        if (f3 >= 3'd3) begin
          f3 = f3 + 3'd1;
        end
        off = rand_below(256) & ~((1 << f3[1:0]) - 1);
        if (mis && f3[1:0] != 2'd0) begin
          off = off + 1;
        end
        imem[i] = i_type(12'(off), 5'd0, f3, rd, 7'b0000011);
      end
      8: begin
        f3 = 3'(rand_below(6));
        if (f3 >= 3'd2) begin
          f3 = f3 + 3'd2;
        end
        imem[i] = b_type(13'(4 * k), rs2, rs1, f3);
      end
      default: begin
        // JAL relative or JALR to an absolute word address
        if (rand_below(2) == 0) begin
          imem[i] = j_type(21'(4 * k), rd);
        end else begin
          imem[i] = i_type(12'(4 * (i + k)), 5'd0, 3'd0, rd, 7'b1100111);
        end
      end
    endcase
  end
  imem[PROG_LEN - 1] = 32'h0000_0073;
  // ADDI x0 no-ops tagged with their word index fill the rest
  for (i = PROG_LEN; i < 256; i++) begin
    imem[i] = i_type(12'(i), 5'd0, 3'd0, 5'd0, 7'b0010011);
  end
endtask

function automatic word_t alu_model(input logic [2:0] f3, input logic alt,
                                    input word_t a, input word_t b);
  case (f3)
    3'd0:    return alt ? a - b : a + b;
    3'd1:    return a << b[4:0];
    3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    3'd3:    return (a < b) ? 32'd1 : 32'd0;
    3'd4:    return a ^ b;
    3'd5:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
    3'd6:    return a | b;
    default: return a & b;
  endcase
endfunction

function automatic logic branch_model(input logic [2:0] f3, input word_t a, input word_t b);
  case (f3)
    3'd0:    return a == b;
    3'd1:    return a != b;
    3'd4:    return $signed(a) < $signed(b);
    3'd5:    return $signed(a) >= $signed(b);
    3'd6:    return a < b;
    default: return a >= b;
  endcase
endfunction

// Little-endian read from the model memory
function automatic word_t load_model(input logic [2:0] f3, input logic [7:0] ad);
  logic [7:0]  lo;
  logic [15:0] half;
  lo   = m_mem[ad];
  half = {m_mem[ad + 8'd1], m_mem[ad]};
  case (f3)
    3'd0:    return {{24{lo[7]}}, lo};
    3'd1:    return {{16{half[15]}}, half};
    3'd4:    return {24'd0, lo};
    3'd5:    return {16'd0, half};
    default: return {m_mem[ad + 8'd3], m_mem[ad + 8'd2], half};
  endcase
endfunction

// ISA-level run with one expectation per execute cycle
task automatic run_model();
  word_t      pc, next, ins, a, b, val, addr, wd;
  word_t      imm_i, imm_s, imm_b, imm_u, imm_j;
  logic [2:0] f3;
  logic [4:0] rd;
  logic [3:0] be;
  logic [1:0] kind;
  logic       wr, taken, done, mis;
  int         steps;
  int         k;
  pc             = `TSPP_RESET_PC;
  done           = 1'b0;
  steps          = 0;
  exp_writes     = 0;
  exp_halt_fetch = '0;
  for (k = 0; k < 32; k++) begin
    m_regs[k] = '0;
  end
  while (!done && steps < 4 * PROG_LEN) begin
    ins   = imem[pc[9:2]];
    f3    = ins[14:12];
    rd    = ins[11:7];
    a     = m_regs[ins[19:15]];
    b     = m_regs[ins[24:20]];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    imm_u = {ins[31:12], 12'h000};
    imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    next  = pc + 32'd4;
    wr    = 1'b0;
    val   = '0;
    taken = 1'b0;
    kind  = EV_IDLE;
    addr  = '0;
    be    = '0;
    wd    = '0;
    mis   = 1'b0;
    case (ins[6:0])
      7'b0110111: begin
        wr  = 1'b1;
        val = imm_u;
      end
      7'b0010111: begin
        wr  = 1'b1;
        val = pc + imm_u;
      end
      7'b1101111: begin
        wr    = 1'b1;
        val   = pc + 32'd4;
        taken = 1'b1;
        next  = pc + imm_j;
      end
      7'b1100111: begin
        wr    = 1'b1;
        val   = pc + 32'd4;
        taken = 1'b1;
        next  = (a + imm_i) & ~32'd1;
      end
      7'b1100011: begin
        taken = branch_model(f3, a, b);
        if (taken) begin
          next = pc + imm_b;
        end
      end
      7'b0000011, 7'b0100011: begin
        addr = a + ((ins[5]) ? imm_s : imm_i);
        mis  = (f3[1:0] == 2'd1 && addr[0]) || (f3[1:0] == 2'd2 && addr[1:0] != 2'd0);
        if (mis) begin
          kind = EV_FAULT;
        end else if (!ins[5]) begin
          // Aligned load writes rd
          kind = EV_LOAD;
          wr   = 1'b1;
          val  = load_model(f3, addr[7:0]);
        end else begin
          kind = EV_STORE;
          case (f3[1:0])
            2'd0:    be = 4'b0001 << addr[1:0];
            2'd1:    be = 4'b0011 << addr[1:0];
            default: be = 4'b1111;
          endcase
          wd = b << (8 * addr[1:0]);
          for (k = 0; k < 4; k++) begin
            if (be[k]) begin
              m_mem[{addr[7:2], 2'(k)}] = wd[8 * k +: 8];
            end
          end
          exp_writes++;
        end
      end
      7'b0010011: begin
        wr  = 1'b1;
        val = alu_model(f3, (f3 == 3'd5) && ins[30], a, imm_i);
      end
      7'b0110011: begin
        wr  = 1'b1;
        val = alu_model(f3, ins[30], a, b);
      end
      7'b1110011: begin
        // Fetch still steps once past the slot after ECALL before it freezes
        done           = 1'b1;
        exp_halt_fetch = pc + 32'd8;
      end
      default: begin
      end
    endcase
    if (wr && rd != 5'd0) begin
      m_regs[rd] = val;
    end
    // Execute cycle sees the next sequential fetch address
    exp_q.push_back('{fetch_addr: pc + 32'd4, kind: kind, addr: addr, byte_en: be,
                      wdata: wd});
    // Squash bubble while fetch restarts at the target
    if (taken) begin
      exp_q.push_back('{fetch_addr: next, kind: EV_IDLE, addr: '0, byte_en: '0,
                        wdata: '0});
    end
    pc = next;
    steps++;
  end
endtask

`endif

// File: testbench/tb_tspp.sv
`timescale 1ns/1ps
`include "tspp_config.svh"

module tb_tspp;

  import tspp_pkg::*;

  localparam int PROG_LEN         = 200;
  localparam int RESET_CYCLES     = 10;
  localparam int POST_HALT_CYCLES = 8;
  // At most two cycles per instruction, plus margin
  localparam int TIMEOUT_CYCLES   = PROG_LEN * 2 + 100;

  // Test groups
  localparam int T_RESET   = 0;
  localparam int T_BUS     = 1;
  localparam int T_FLOW    = 2;
  localparam int T_FAULT   = 3;
  localparam int T_HALT    = 4;
  localparam int NUM_TESTS = 5;

  logic      CLK = 1'b0;
  logic      nRST;
  word_t     imem_addr;
  word_t     imem_rdata;
  dbus_req_t dbus;
  word_t     dmem_rdata;
  logic      fault;
  logic      halt;

  word_t      imem [256];
  logic [7:0] dmem [256];

  int    test_checks [NUM_TESTS];
  int    test_errs   [NUM_TESTS];
  string test_names  [NUM_TESTS] = '{"reset_outputs", "store_bus", "fetch_redirect",
                                     "misaligned_fault", "halt_stop"};
  int    cycle_count = 0;
  int    dut_writes;

  `include "tb_model.svh"

  tspp_top UUT (
    .CLK        (CLK),
    .nRST       (nRST),
    .imem_addr  (imem_addr),
    .imem_rdata (imem_rdata),
    .dbus       (dbus),
    .dmem_rdata (dmem_rdata),
    .fault      (fault),
    .halt       (halt)
  );

  always #2 CLK = ~CLK;

  // Watchdog on cycles since reset release
  always @(posedge CLK) begin
    if (nRST) begin
      cycle_count = cycle_count + 1;
    end
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: halt not reached within %0d cycles", TIMEOUT_CYCLES);
      $display("Finished with errors");
      $finish;
    end
  end

  task automatic check_value(input int t, input string name, input word_t exp,
                             input word_t got);
    test_checks[t]++;
    assert (got === exp) else begin
      $display("Error: %s expected %h got %h", name, exp, got);
      test_errs[t]++;
    end
  endtask

  function automatic word_t lane_mask(input logic [3:0] be);
    return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
  endfunction

  task automatic verify_reset_state();
    check_value(T_RESET, "halt", 32'd0, word_t'(halt));
    check_value(T_RESET, "fault", 32'd0, word_t'(fault));
    check_value(T_RESET, "dbus.ren", 32'd0, word_t'(dbus.ren));
    check_value(T_RESET, "dbus.wen", 32'd0, word_t'(dbus.wen));
    check_value(T_RESET, "imem_addr", `TSPP_RESET_PC, imem_addr);
  endtask

  task automatic compare_cycle(input cycle_exp_t e);
    int    t;
    word_t mask;
    // Strobes in a faulting cycle belong to the fault test
    t    = (e.kind == EV_FAULT) ? T_FAULT : T_BUS;
    mask = lane_mask(e.byte_en);
    check_value(T_FLOW, "imem_addr", e.fetch_addr, imem_addr);
    check_value(T_HALT, "halt", 32'd0, word_t'(halt));
    check_value(T_FAULT, "fault", word_t'(e.kind == EV_FAULT), word_t'(fault));
    check_value(t, "dbus.ren", word_t'(e.kind == EV_LOAD), word_t'(dbus.ren));
    check_value(t, "dbus.wen", word_t'(e.kind == EV_STORE), word_t'(dbus.wen));
    if (e.kind == EV_LOAD || e.kind == EV_STORE) begin
      check_value(T_BUS, "dbus.addr", e.addr, dbus.addr);
    end
    if (e.kind == EV_STORE) begin
      check_value(T_BUS, "dbus.byte_en", word_t'(e.byte_en), word_t'(dbus.byte_en));
      // Only enabled lanes carry data
      check_value(T_BUS, "dbus.wdata", e.wdata & mask, dbus.wdata & mask);
    end
  endtask

  // Data memory takes the write seen in this cycle
  task automatic commit_store();
    logic [5:0] w;
    int         k;
    if (dbus.wen) begin
      w = dbus.addr[7:2];
      for (k = 0; k < 4; k++) begin
        if (dbus.byte_en[k]) begin
          dmem[{w, 2'(k)}] = dbus.wdata[8 * k +: 8];
        end
      end
      dut_writes++;
    end
  endtask

  // Read data for the addresses the DUT presents this cycle
  task automatic drive_memories();
    logic [5:0] w;
    imem_rdata = imem[imem_addr[9:2]];
    w          = dbus.addr[7:2];
    if (dbus.ren) begin
      dmem_rdata = {dmem[{w, 2'd3}], dmem[{w, 2'd2}], dmem[{w, 2'd1}], dmem[{w, 2'd0}]};
    end else begin
      dmem_rdata = '0;
    end
  endtask

  task automatic report_test(input int t);
    $display("Test %s: %0d checks, %0d errors", test_names[t], test_checks[t], test_errs[t]);
  endtask

  initial begin
    cycle_exp_t e;
    word_t      halt_addr;
    int         i;
    int         total_checks;
    int         total_errs;
    nRST       = 1'b0;
    imem_rdata = '0;
    dmem_rdata = '0;
    dut_writes = 0;
    for (i = 0; i < NUM_TESTS; i++) begin
      test_checks[i] = 0;
      test_errs[i]   = 0;
    end
    seed = 99235;
    gen_program();
    // Same starting contents for DUT memory and model memory
    for (i = 0; i < 256; i++) begin
      dmem[i]  = fill_byte(i);
      m_mem[i] = fill_byte(i);
    end
    run_model();
    drive_memories();

    for (i = 0; i < RESET_CYCLES; i++) begin
      @(negedge CLK);
      verify_reset_state();
      drive_memories();
    end
    nRST = 1'b1;
    // Reset released before the first active edge
    verify_reset_state();
    report_test(T_RESET);

    while (exp_q.size() > 0) begin
      @(negedge CLK);
      e = exp_q.pop_front();
      compare_cycle(e);
      commit_store();
      drive_memories();
    end
    report_test(T_BUS);
    report_test(T_FLOW);
    report_test(T_FAULT);

    // Halt holds from the edge that ends ECALL and fetch stays frozen
    halt_addr = exp_halt_fetch;
    for (i = 0; i < POST_HALT_CYCLES; i++) begin
      @(negedge CLK);
      check_value(T_HALT, "halt", 32'd1, word_t'(halt));
      check_value(T_HALT, "dbus.ren", 32'd0, word_t'(dbus.ren));
      check_value(T_HALT, "dbus.wen", 32'd0, word_t'(dbus.wen));
      check_value(T_HALT, "fault", 32'd0, word_t'(fault));
      check_value(T_HALT, "imem_addr", halt_addr, imem_addr);
      commit_store();
      drive_memories();
    end
    check_value(T_HALT, "write count", word_t'(exp_writes), word_t'(dut_writes));
    report_test(T_HALT);

    total_checks = 0;
    total_errs   = 0;
    for (i = 0; i < NUM_TESTS; i++) begin
      total_checks += test_checks[i];
      total_errs   += test_errs[i];
    end
    $display("Total: %0d checks, %0d errors, %0d stores", total_checks, total_errs,
             dut_writes);
    if (total_errs == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: hdl/tspp_top.sv
`timescale 1ns/1ps

module tspp_top (
  input  logic                CLK,
  input  logic                nRST,
  output tspp_pkg::word_t     imem_addr,
  input  tspp_pkg::word_t     imem_rdata,
  output tspp_pkg::dbus_req_t dbus,
  input  tspp_pkg::word_t     dmem_rdata,
  output logic                fault,
  output logic                halt
);

  import tspp_pkg::*;

  // Stage-to-stage wires
  fetch_ex_t fetch_ex;
  logic      redirect;
  word_t     redirect_addr;

  fetch_stage fetch (
    .CLK           (CLK),
    .nRST          (nRST),
    .redirect      (redirect),
    .redirect_addr (redirect_addr),
    .halt          (halt),
    .imem_addr     (imem_addr),
    .imem_rdata    (imem_rdata),
    .fetch_ex      (fetch_ex)
  );

  execute_stage execute (
    .CLK           (CLK),
    .nRST          (nRST),
    .fetch_ex      (fetch_ex),
    .redirect      (redirect),
    .redirect_addr (redirect_addr),
    .dbus          (dbus),
    .dmem_rdata    (dmem_rdata),
    .fault         (fault),
    .halt          (halt)
  );

endmodule

// File: hdl/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
  input  logic                CLK,
  input  logic                nRST,
  input  tspp_pkg::fetch_ex_t fetch_ex,
  output logic                redirect,
  output tspp_pkg::word_t     redirect_addr,
  output tspp_pkg::dbus_req_t dbus,
  input  tspp_pkg::word_t     dmem_rdata,
  output logic                fault,
  output logic                halt
);

  import tspp_pkg::*;

  ctrl_t      ctrl;
  word_t      rs1_data, rs2_data;
  word_t      port_a, port_b, alu_out;
  word_t      jump_addr, br_target, wb_data, load_ext;
  logic       br_taken, valid, mal_addr, rf_wen;
  logic [1:0] byte_offset;
  logic [3:0] byte_en;
  logic [7:0] ld_byte;
  logic [15:0] ld_half;

  // The slot right after ECALL is dead even if fetch marked it valid
  assign valid = fetch_ex.valid & ~halt;

  control_unit cu (
    .instr (fetch_ex.instr),
    .ctrl  (ctrl)
  );

  reg_file rf (
    .CLK      (CLK),
    .nRST     (nRST),
    .rs1_sel  (ctrl.rs1_sel),
    .rs2_sel  (ctrl.rs2_sel),
    .rd_sel   (ctrl.rd_sel),
    .wen      (rf_wen),
    .wdata    (wb_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  alu alu_i (
    .aluop    (ctrl.aluop),
    .port_a   (port_a),
    .port_b   (port_b),
    .port_out (alu_out)
  );

  branch_res br (
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .pc          (fetch_ex.pc),
    .imm_sb      (ctrl.imm_b),
    .branch_type (ctrl.branch_type),
    .taken       (br_taken),
    .target      (br_target)
  );

  // Operand muxes
  assign port_a = ctrl.alu_a_sel ? fetch_ex.pc : rs1_data;

  always_comb begin
    case (ctrl.alu_b_sel)
      2'd0:    port_b = rs2_data;
      2'd1:    port_b = ctrl.imm_i;
      2'd2:    port_b = ctrl.imm_s;
      default: port_b = ctrl.imm_u;
    endcase
  end

  // JAL is pc relative, JALR clears bit 0 of rs1 plus offset
  assign jump_addr = ctrl.j_sel ? fetch_ex.pc + ctrl.imm_j
                                : (rs1_data + ctrl.imm_i) & ~32'd1;

  assign redirect      = valid & (ctrl.jump | (ctrl.branch & br_taken));
  assign redirect_addr = ctrl.jump ? jump_addr : br_target;

  // Lane select from the low address bits
  assign byte_offset = alu_out[1:0];

  always_comb begin
    case (ctrl.load_type)
      LB, LBU: byte_en = 4'b0001 << byte_offset;
      LH, LHU: byte_en = byte_offset[1] ? 4'b1100 : 4'b0011;
      LW:      byte_en = 4'b1111;
      default: byte_en = 4'b0000;
    endcase
  end

  // Halfwords need even addresses, words need offset 0
  always_comb begin
    case (ctrl.load_type)
      LH, LHU: mal_addr = byte_offset[0];
      LW:      mal_addr = (byte_offset != 2'b00);
      default: mal_addr = 1'b0;
    endcase
  end

  assign fault = valid & (ctrl.dren | ctrl.dwen) & mal_addr;

  assign dbus.addr    = alu_out;
  assign dbus.byte_en = byte_en;
  assign dbus.ren     = valid & ctrl.dren & ~mal_addr;
  assign dbus.wen     = valid & ctrl.dwen & ~mal_addr;

  // Store data copied into every lane, byte_en picks the live ones
  always_comb begin
    case (ctrl.load_type)
      LB, LBU: dbus.wdata = {4{rs2_data[7:0]}};
      LH, LHU: dbus.wdata = {2{rs2_data[15:0]}};
      default: dbus.wdata = rs2_data;
    endcase
  end

  // Load lane extraction, little-endian
  assign ld_byte = dmem_rdata[8*byte_offset +: 8];
  assign ld_half = byte_offset[1] ? dmem_rdata[31:16] : dmem_rdata[15:0];

  always_comb begin
    case (ctrl.load_type)
      LB:      load_ext = {{24{ld_byte[7]}}, ld_byte};
      LBU:     load_ext = {24'b0, ld_byte};
      LH:      load_ext = {{16{ld_half[15]}}, ld_half};
      LHU:     load_ext = {16'b0, ld_half};
      default: load_ext = dmem_rdata;
    endcase
  end

  // Write-back source
  always_comb begin
    case (ctrl.w_sel)
      2'd0:    wb_data = load_ext;
      2'd1:    wb_data = fetch_ex.pc4;
      2'd2:    wb_data = ctrl.imm_u;
      default: wb_data = alu_out;
    endcase
  end

  // A misaligned load leaves rd untouched
  assign rf_wen = valid & ctrl.wen & ~(ctrl.dren & mal_addr);

  // Sticky until reset
  always_ff @(posedge CLK, negedge nRST) begin
    if (~nRST) begin
      halt <= 1'b0;
    end else if (valid & ctrl.halt) begin
      halt <= 1'b1;
    end
  end

  bus_strobes_exclusive: assert property (@(posedge CLK) disable iff (~nRST)
    !(dbus.ren && dbus.wen))
    else $error("dbus ren and wen both high");

  strobe_has_lanes: assert property (@(posedge CLK) disable iff (~nRST)
    (dbus.ren || dbus.wen) |-> (dbus.byte_en != 4'b0000))
    else $error("dbus strobe with zero byte_en");

  halt_is_sticky: assert property (@(posedge CLK) disable iff (~nRST)
    halt |=> halt)
    else $error("halt fell without reset");

endmodule

// File: hdl/fetch_stage.sv
`timescale 1ns/1ps
`include "tspp_config.svh"

module fetch_stage (
  input  logic                CLK,
  input  logic                nRST,
  input  logic                redirect,
  input  tspp_pkg::word_t     redirect_addr,
  input  logic                halt,
  output tspp_pkg::word_t     imem_addr,
  input  tspp_pkg::word_t     imem_rdata,
  output tspp_pkg::fetch_ex_t fetch_ex
);

  import tspp_pkg::*;

  word_t pc, pc_next;
  word_t fe_pc, fe_pc4, fe_instr;
  logic  fe_valid;

  // Predict not taken, redirect from execute overrides
  assign pc_next = redirect ? redirect_addr : pc + 32'd4;

  always_ff @(posedge CLK, negedge nRST) begin
    if (~nRST) begin
      pc <= `TSPP_RESET_PC;
    end else if (~halt) begin
      pc <= pc_next;
    end
  end

  assign imem_addr = pc;

  // Valid drops on a redirect (squash) and stays low once halted
  always_ff @(posedge CLK, negedge nRST) begin
    if (~nRST) begin
      fe_valid <= 1'b0;
    end else begin
      fe_valid <= ~halt & ~redirect;
    end
  end

  // Payload
  always_ff @(posedge CLK) begin
    if (~halt) begin
      fe_pc    <= pc;
      fe_pc4   <= pc + 32'd4;
      fe_instr <= imem_rdata;
    end
  end

  assign fetch_ex = '{pc: fe_pc, pc4: fe_pc4, instr: fe_instr, valid: fe_valid};

endmodule

// File: hdl/branch_res.sv
`timescale 1ns/1ps

module branch_res (
  input  tspp_pkg::word_t   rs1_data,
  input  tspp_pkg::word_t   rs2_data,
  input  tspp_pkg::word_t   pc,
  input  tspp_pkg::word_t   imm_sb,
  input  tspp_pkg::branch_t branch_type,
  output logic              taken,
  output tspp_pkg::word_t   target
);

  import tspp_pkg::*;

  logic eq, lt, ltu;

  // Shared comparators for all six conditions
  assign eq  = (rs1_data == rs2_data);
  assign lt  = ($signed(rs1_data) < $signed(rs2_data));
  assign ltu = (rs1_data < rs2_data);

  always_comb begin
    case (branch_type)
      BEQ:     taken = eq;
      BNE:     taken = ~eq;
      BLT:     taken = lt;
      BGE:     taken = ~lt;
      BLTU:    taken = ltu;
      BGEU:    taken = ~ltu;
      default: taken = 1'b0;
    endcase
  end

  // PC-relative target, offset already carries the zero LSB
  assign target = pc + imm_sb;

endmodule

// File: hdl/alu.sv
`timescale 1ns/1ps

module alu (
  input  tspp_pkg::aluop_t aluop,
  input  tspp_pkg::word_t  port_a,
  input  tspp_pkg::word_t  port_b,
  output tspp_pkg::word_t  port_out
);

  import tspp_pkg::*;

  logic [4:0] shamt;

  // Shift amount from the low five bits only
  assign shamt = port_b[4:0];

  always_comb begin
    case (aluop)
      ALU_ADD:  port_out = port_a + port_b;
      ALU_SUB:  port_out = port_a - port_b;
      ALU_SLL:  port_out = port_a << shamt;
      // Set-less-than results are 0 or 1
      ALU_SLT:  port_out = {31'b0, $signed(port_a) < $signed(port_b)};
      ALU_SLTU: port_out = {31'b0, port_a < port_b};
      ALU_XOR:  port_out = port_a ^ port_b;
      ALU_SRL:  port_out = port_a >> shamt;
      // Arithmetic shift keeps the sign bit
      ALU_SRA:  port_out = word_t'($signed(port_a) >>> shamt);
      ALU_OR:   port_out = port_a | port_b;
      ALU_AND:  port_out = port_a & port_b;
      default:  port_out = '0;
    endcase
  end

endmodule

// File: hdl/reg_file.sv
`timescale 1ns/1ps
`include "tspp_config.svh"

module reg_file (
  input  logic            CLK,
  input  logic            nRST,
  input  logic [4:0]      rs1_sel,
  input  logic [4:0]      rs2_sel,
  input  logic [4:0]      rd_sel,
  input  logic            wen,
  input  tspp_pkg::word_t wdata,
  output tspp_pkg::word_t rs1_data,
  output tspp_pkg::word_t rs2_data
);

  import tspp_pkg::*;

  word_t regs [`TSPP_NREGS];

  // Write on the clock edge, x0 never written
  always_ff @(posedge CLK, negedge nRST) begin
    if (~nRST) begin
      for (int i = 0; i < `TSPP_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && (rd_sel != 5'd0)) begin
      regs[rd_sel] <= wdata;
    end
  end

  // Reads are combinational
  assign rs1_data = regs[rs1_sel];
  assign rs2_data = regs[rs2_sel];

  // x0 stays zero across all writes since reset
  x0_reads_zero: assert property (@(posedge CLK) disable iff (~nRST)
    ((rs1_sel == 5'd0) -> (rs1_data == '0)) && ((rs2_sel == 5'd0) -> (rs2_data == '0)))
    else $error("x0 read back nonzero");

endmodule

// File: hdl/control_unit.sv
`timescale 1ns/1ps

module control_unit (
  input  tspp_pkg::word_t instr,
  output tspp_pkg::ctrl_t ctrl
);

  import tspp_pkg::*;

  opcode_t    opcode;
  logic [2:0] funct3;

  assign opcode = opcode_t'(instr[6:0]);
  assign funct3 = instr[14:12];

  // ALU function from funct3, alt is instr[30]
  // Immediate forms have no SUB, so alt only matters for shifts there
  function automatic aluop_t decode_alu(input logic [2:0] f3, input logic alt,
                                        input logic is_reg);
    aluop_t op;
    case (f3)
      3'b000:  op = (alt && is_reg) ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  always_comb begin
    // Everything off by default, so an unknown opcode is a no-op
    ctrl = '0;
    ctrl.rs1_sel     = instr[19:15];
    ctrl.rs2_sel     = instr[24:20];
    ctrl.rd_sel      = instr[11:7];
    ctrl.aluop       = ALU_ADD;
    ctrl.load_type   = load_t'(funct3);
    ctrl.branch_type = branch_t'(funct3);
    // Sign-extended immediates
    ctrl.imm_i = {{20{instr[31]}}, instr[31:20]};
    ctrl.imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    ctrl.imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    ctrl.imm_u = {instr[31:12], 12'b0};
    ctrl.imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // w_sel: 0 load, 1 pc4, 2 U immediate, 3 ALU
    // alu_b_sel: 0 rs2, 1 I imm, 2 S imm, 3 U imm
    case (opcode)
      LUI: begin
        ctrl.wen   = 1'b1;
        ctrl.w_sel = 2'd2;
      end
      AUIPC: begin
        ctrl.wen       = 1'b1;
        ctrl.alu_a_sel = 1'b1;
        ctrl.alu_b_sel = 2'd3;
        ctrl.w_sel     = 2'd3;
      end
      JAL: begin
        ctrl.wen   = 1'b1;
        ctrl.w_sel = 2'd1;
        ctrl.jump  = 1'b1;
        ctrl.j_sel = 1'b1;
      end
      JALR: begin
        // Target from rs1, link in rd
        ctrl.wen   = 1'b1;
        ctrl.w_sel = 2'd1;
        ctrl.jump  = 1'b1;
      end
      BRANCH: begin
        ctrl.branch = 1'b1;
      end
      LOAD: begin
        ctrl.wen       = 1'b1;
        ctrl.dren      = 1'b1;
        ctrl.alu_b_sel = 2'd1;
        ctrl.w_sel     = 2'd0;
      end
      STORE: begin
        ctrl.dwen      = 1'b1;
        ctrl.alu_b_sel = 2'd2;
      end
      IMM: begin
        ctrl.wen       = 1'b1;
        ctrl.alu_b_sel = 2'd1;
        ctrl.aluop     = decode_alu(funct3, instr[30], 1'b0);
        ctrl.w_sel     = 2'd3;
      end
      REG: begin
        ctrl.wen       = 1'b1;
        ctrl.alu_b_sel = 2'd0;
        ctrl.aluop     = decode_alu(funct3, instr[30], 1'b1);
        ctrl.w_sel     = 2'd3;
      end
      SYSTEM: begin
        // ECALL only, CSR forms fall through as no-ops
        ctrl.halt = (funct3 == 3'b000) && (instr[31:20] == 12'h000);
      end
      default: begin
      end
    endcase
  end

endmodule

// File: hdl/tspp_pkg.sv
package tspp_pkg;

  // Data or address word
  typedef logic [31:0] word_t;

  // RV32I major opcodes, bits [6:0] of the instruction
  typedef enum logic [6:0] {
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    BRANCH = 7'b1100011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    IMM    = 7'b0010011,
    REG    = 7'b0110011,
    SYSTEM = 7'b1110011
  } opcode_t;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
  } aluop_t;

  // Encoded as funct3 of the branch instructions
  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } branch_t;

  // funct3 of loads, stores share the same encoding for B/H/W
  typedef enum logic [2:0] {
    LB  = 3'b000,
    LH  = 3'b001,
    LW  = 3'b010,
    LBU = 3'b100,
    LHU = 3'b101
  } load_t;

  // Fetch-to-execute pipeline register
  typedef struct packed {
    word_t pc;
    word_t pc4;
    word_t instr;
    logic  valid;
  } fetch_ex_t;

  // Decoded controls and immediates
  typedef struct packed {
    logic       wen;
    logic [4:0] rs1_sel;
    logic [4:0] rs2_sel;
    logic [4:0] rd_sel;
    logic       alu_a_sel;
    logic [1:0] alu_b_sel;
    aluop_t     aluop;
    logic [1:0] w_sel;
    logic       dren;
    logic       dwen;
    load_t      load_type;
    logic       branch;
    branch_t    branch_type;
    logic       jump;
    logic       j_sel;
    logic       halt;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;
  } ctrl_t;

  // Data bus request, strobes are single-cycle
  typedef struct packed {
    word_t      addr;
    word_t      wdata;
    logic [3:0] byte_en;
    logic       ren;
    logic       wen;
  } dbus_req_t;

endpackage

// File: hdl/tspp_config.svh
`ifndef TSPP_CONFIG_SVH
`define TSPP_CONFIG_SVH

// First fetch address after reset
`define TSPP_RESET_PC 32'h0000_0000

// Architectural integer registers
`define TSPP_NREGS 32

`endif
